// File: compile.f
rtl/fetch_pkg.sv
rtl/mmu_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_pc_sel.sv
rtl/fetch_addr_xlate.sv
rtl/fetch_inst_buf.sv
rtl/fetch_stage.sv
tests/fetch_env.sv
tests/tb_fetch_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_fetch_stage \
    -Mdir obj_dir > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_fetch_stage > sim.log 2>&1

grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tests/tb_fetch_stage.sv
`timescale 1ns/100ps

module tb_fetch_stage;

    localparam logic [31:0] PATTERN    = 32'h5a5a_0ff0;
    localparam int          N_ROWS     = 13;
    localparam int          ROW_CYCLES = 150;

    localparam int K_SEQ     = 0;
    localparam int K_BR      = 1;   // branch with a request possibly accepted that cycle
    localparam int K_BR_HOLD = 2;   // branch while br_stall blocks the request
    localparam int K_FL_BR   = 3;   // flush and branch together
    localparam int K_STALL   = 4;

    typedef struct {
        int          kind;
        logic [31:0] start;
        logic [31:0] target;
        int          map_sel;
        int          allow_pct;
        int          n_chk;
        logic [31:0] phys;      // physical address of start
        logic [5:0]  ecode;     // 0 for a normal fetch
    } row_t;

    logic        clk;
    logic        resetn;
    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic        id_allowin;
    logic        br_taken;
    logic [31:0] br_target;
    logic        br_stall;
    logic        if_to_id_valid;
    logic [31:0] if_inst;
    logic [31:0] if_pc;
    logic        if_excep_en;
    logic [5:0]  if_ecode;
    logic [31:0] if_badv;
    logic        flush;
    logic [31:0] flush_entry;
    logic [18:0] s0_vppn;
    logic        s0_va_bit12;
    logic        s0_found;
    logic [19:0] s0_ppn;
    logic [5:0]  s0_ps;
    logic [1:0]  s0_plv;
    logic        s0_v;
    logic        csr_crmd_pg;
    logic [1:0]  csr_crmd_plv;
    logic        dmw0_plv_met;
    logic [2:0]  dmw0_vseg;
    logic [2:0]  dmw0_pseg;
    logic        dmw1_plv_met;
    logic [2:0]  dmw1_vseg;
    logic [2:0]  dmw1_pseg;
    logic        ent_en;
    logic [18:0] ent_vppn;
    logic [19:0] ent_ppn;
    logic [5:0]  ent_ps;
    logic [1:0]  ent_plv;
    logic        ent_v;

    row_t   rows[$];
    integer seed;
    int     errors;
    int     checks;
    int     passed;

    fetch_stage dut_i (
        .clk (clk), .resetn (resetn),
        .inst_sram_req (inst_sram_req), .inst_sram_addr (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok), .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata (inst_sram_rdata),
        .id_allowin (id_allowin), .br_taken (br_taken), .br_target (br_target),
        .br_stall (br_stall), .if_to_id_valid (if_to_id_valid), .if_inst (if_inst),
        .if_pc (if_pc), .if_excep_en (if_excep_en), .if_ecode (if_ecode), .if_badv (if_badv),
        .flush (flush), .flush_entry (flush_entry),
        .s0_vppn (s0_vppn), .s0_va_bit12 (s0_va_bit12), .s0_found (s0_found),
        .s0_ppn (s0_ppn), .s0_ps (s0_ps), .s0_plv (s0_plv), .s0_v (s0_v),
        .csr_crmd_pg (csr_crmd_pg), .csr_crmd_plv (csr_crmd_plv),
        .dmw0_plv_met (dmw0_plv_met), .dmw0_vseg (dmw0_vseg), .dmw0_pseg (dmw0_pseg),
        .dmw1_plv_met (dmw1_plv_met), .dmw1_vseg (dmw1_vseg), .dmw1_pseg (dmw1_pseg)
    );

    fetch_env #(.PATTERN (PATTERN)) env_i (
        .clk (clk), .resetn (resetn),
        .inst_sram_req (inst_sram_req), .inst_sram_addr (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok), .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata (inst_sram_rdata), .s0_vppn (s0_vppn), .s0_va_bit12 (s0_va_bit12),
        .ent_en (ent_en), .ent_vppn (ent_vppn), .ent_ppn (ent_ppn), .ent_ps (ent_ps),
        .ent_plv (ent_plv), .ent_v (ent_v), .s0_found (s0_found), .s0_ppn (s0_ppn),
        .s0_ps (s0_ps), .s0_plv (s0_plv), .s0_v (s0_v)
    );

    always #5 clk = ~clk;

    task automatic add_row(input int kind, input logic [31:0] start, input logic [31:0] target,
                           input int map_sel, input int allow_pct, input int n_chk,
                           input logic [31:0] phys, input logic [5:0] ecode);
        row_t r;
        r.kind = kind;
        r.start = start;
        r.target = target;
        r.map_sel = map_sel;
        r.allow_pct = allow_pct;
        r.n_chk = n_chk;
        r.phys = phys;
        r.ecode = ecode;
        rows.push_back(r);
    endtask

    // csr and tlb setup for one row
    task automatic apply_map(input int sel);
        csr_crmd_pg  = (sel != 0);
        csr_crmd_plv = (sel == 7) ? 2'd3 : 2'd0;
        dmw0_plv_met = (sel == 1) || (sel == 2);
        dmw0_vseg    = 3'h4;
        dmw0_pseg    = 3'h0;
        dmw1_plv_met = (sel == 1) || (sel == 2);
        dmw1_vseg    = (sel == 1) ? 3'h4 : 3'h5;    // overlaps window 0 under map 1
        dmw1_pseg    = (sel == 1) ? 3'h7 : 3'h1;
        ent_en       = (sel == 3) || (sel == 4) || (sel == 6) || (sel == 7);
        ent_vppn     = (sel == 4) ? 19'h00600 : 19'h00200;
        ent_ppn      = (sel == 4) ? 20'h1c000 : 20'h12344;
        ent_ps       = (sel == 4) ? mmu_pkg::PS_4M : 6'd12;
        ent_plv      = 2'd0;
        ent_v        = (sel != 6);
    endtask

    task automatic report_error(input int idx, input string msg);
        errors++;
        $display("** Error at %0t: test %0d %s", $time, idx, msg);
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] exp_pc;
        logic [31:0] exp_data;
        int          got;
        int          reqs;
        int          cycles;
        int          stall_left;
        int          errs_before;
        bit          event_done;
        r = rows[idx];
        errs_before = errors;
        got = 0;
        reqs = 0;
        cycles = 0;
        stall_left = 0;
        event_done = (r.kind == K_SEQ);
        @(posedge clk);
        #1;
        apply_map(r.map_sel);
        flush = 1'b1;                   // every row starts from its own redirect
        flush_entry = r.start;
        exp_pc = r.start;
        while (got < r.n_chk && cycles < ROW_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (inst_sram_req)
                reqs++;
            if (br_stall) begin
                checks++;
                assert (!inst_sram_req) else report_error(idx, "request under br_stall");
            end
            if (if_to_id_valid && id_allowin) begin
                exp_data = (r.phys + (exp_pc - r.start)) ^ PATTERN;
                checks++;
                if (r.ecode != 6'd0) begin
                    assert (if_excep_en && if_ecode == r.ecode && if_badv == exp_pc
                            && if_pc == exp_pc)
                    else report_error(idx, $sformatf("pc %h excep %b code %h badv %h, want %h/%h",
                                      if_pc, if_excep_en, if_ecode, if_badv, exp_pc, r.ecode));
                end else begin
                    assert (!if_excep_en && if_pc == exp_pc && if_inst == exp_data)
                    else report_error(idx, $sformatf("pc %h inst %h, want pc %h inst %h",
                                      if_pc, if_inst, exp_pc, exp_data));
                end
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            @(posedge clk);
            #1;
            flush = 1'b0;
            br_taken = 1'b0;
            if (stall_left > 0)
                stall_left--;
            br_stall = (stall_left > 0);
            id_allowin = ({$random(seed)} % 100) < r.allow_pct;
            if (!event_done && got == 2) begin
                event_done = 1'b1;
                exp_pc = r.target;
                if (r.kind == K_STALL) begin
                    exp_pc = r.start + 32'd8;
                    stall_left = 20;
                    br_stall = 1'b1;
                end else if (r.kind == K_FL_BR) begin
                    flush = 1'b1;
                    flush_entry = r.target;
                    br_taken = 1'b1;
                    br_target = r.target + 32'h100;     // loses to the flush
                end else begin
                    br_taken = 1'b1;
                    br_target = r.target;
                    if (r.kind == K_BR_HOLD) begin
                        br_stall = 1'b1;
                        stall_left = 1;
                    end
                end
            end
        end
        br_stall = 1'b0;
        if (got < r.n_chk)
            report_error(idx, $sformatf("no decode transfer within %0d cycles", ROW_CYCLES));
        if (r.ecode != 6'd0) begin
            checks++;
            assert (reqs == 0) else report_error(idx, "memory request for an excepting pc");
        end
        if (errors == errs_before)
            passed++;
        $display("test %0d kind %0d start %h: %0d transfers, %s", idx, r.kind, r.start, got,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        repeat (N_ROWS * 200 + 20) @(posedge clk);
        $display("watchdog expired, run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        seed = 32'h172b_a24a;
        errors = 0;
        checks = 0;
        passed = 0;
        id_allowin = 1'b0;
        br_taken = 1'b0;
        br_target = 32'h0;
        br_stall = 1'b0;
        flush = 1'b0;
        flush_entry = 32'h0;
        apply_map(0);
        //      kind       start         target        map allow n  phys          ecode
        add_row(K_SEQ,     32'h1c000000, 32'h0,        0,  70,   10, 32'h1c000000, 6'd0);
        add_row(K_BR,      32'h1c000100, 32'h1c000400, 0,  80,   6,  32'h1c000100, 6'd0);
        add_row(K_BR_HOLD, 32'h1c000200, 32'h1c000800, 0,  80,   6,  32'h1c000200, 6'd0);
        add_row(K_FL_BR,   32'h1c000300, 32'h1c001000, 0,  60,   6,  32'h1c000300, 6'd0);
        add_row(K_STALL,   32'h1c003000, 32'h0,        0,  50,   8,  32'h1c003000, 6'd0);
        add_row(K_SEQ,     32'h80001000, 32'h0,        1,  70,   6,  32'h00001000, 6'd0);
        add_row(K_SEQ,     32'ha0002000, 32'h0,        2,  70,   6,  32'h20002000, 6'd0);
        add_row(K_SEQ,     32'h00400ff8, 32'h0,        3,  70,   6,  32'h12344ff8, 6'd0);
        add_row(K_SEQ,     32'h00c01000, 32'h0,        4,  70,   6,  32'h1c001000, 6'd0);
        add_row(K_SEQ,     32'h1c000102, 32'h0,        0,  70,   2,  32'h1c000102, 6'h08);
        add_row(K_SEQ,     32'h00400000, 32'h0,        5,  70,   2,  32'h0,        6'h3f);
        add_row(K_SEQ,     32'h00400000, 32'h0,        6,  70,   2,  32'h0,        6'h03);
        add_row(K_SEQ,     32'h00400000, 32'h0,        7,  70,   2,  32'h0,        6'h07);
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < rows.size(); i++)
            run_row(i);
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 rows.size(), passed, rows.size() - passed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tests/fetch_env.sv
`timescale 1ns/100ps

module fetch_env #(
    parameter logic [31:0] PATTERN = 32'h5a5a_0ff0
) (
    input  logic        clk,
    input  logic        resetn,
    // instruction memory
    input  logic        inst_sram_req,
    input  logic [31:0] inst_sram_addr,
    output logic        inst_sram_addr_ok,
    output logic        inst_sram_data_ok,
    output logic [31:0] inst_sram_rdata,
    // one-entry tlb
    input  logic [18:0] s0_vppn,
    input  logic        s0_va_bit12,
    input  logic        ent_en,
    input  logic [18:0] ent_vppn,
    input  logic [19:0] ent_ppn,
    input  logic [5:0]  ent_ps,
    input  logic [1:0]  ent_plv,
    input  logic        ent_v,
    output logic        s0_found,
    output logic [19:0] s0_ppn,
    output logic [5:0]  s0_ps,
    output logic [1:0]  s0_plv,
    output logic        s0_v
);

    integer      seed;
    logic [31:0] addr_q[$];
    int unsigned ready_q[$];    // cycle from which each word may return
    int unsigned cyc;
    logic        run;
    logic        req_seen;      // request accepted at the coming edge
    logic [31:0] addr_seen;

    // a 4 MB entry matches on the upper vppn bits only
    assign s0_found = ent_en && ((ent_ps == mmu_pkg::PS_4M) ?
                      (ent_vppn[18:9] == s0_vppn[18:9]) : (ent_vppn == s0_vppn));

    // a 4 KB entry covers a page pair and bit 12 picks the odd page
    assign s0_ppn = (ent_ps == mmu_pkg::PS_4M) ? ent_ppn : {ent_ppn[19:1], s0_va_bit12};
    assign s0_ps  = ent_ps;
    assign s0_plv = ent_plv;
    assign s0_v   = ent_v;

    initial begin
        seed              = 32'h172b_a24a;
        cyc               = 0;
        req_seen          = 1'b0;
        addr_seen         = 32'h0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = 32'h0;
    end

    // request and address have settled half a cycle before the edge
    always @(negedge clk) begin
        req_seen  = inst_sram_req && inst_sram_addr_ok;
        addr_seen = inst_sram_addr;
    end

    always @(posedge clk) begin
        run = resetn;
        if (!run) begin
            addr_q.delete();
            ready_q.delete();
        end else begin
            if (inst_sram_data_ok) begin
                void'(addr_q.pop_front());
                void'(ready_q.pop_front());
            end
            if (req_seen) begin
                addr_q.push_back(addr_seen);
                ready_q.push_back(cyc + 1 + {$random(seed)} % 4);  // one to four cycles
            end
        end
        cyc = cyc + 1;
        #1;
        inst_sram_addr_ok = run && ({$random(seed)} % 4 != 0);
        inst_sram_data_ok = run && (addr_q.size() > 0) && (ready_q[0] <= cyc);
        inst_sram_rdata   = (addr_q.size() > 0) ? (addr_q[0] ^ PATTERN) : 32'h0;
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              resetn,
    // instruction memory
    output logic              inst_sram_req,
    output fetch_pkg::addr_t  inst_sram_addr,
    input  logic              inst_sram_addr_ok,
    input  logic              inst_sram_data_ok,
    input  fetch_pkg::inst_t  inst_sram_rdata,
    // decode
    input  logic              id_allowin,
    input  logic              br_taken,
    input  fetch_pkg::addr_t  br_target,
    input  logic              br_stall,
    output logic              if_to_id_valid,
    output fetch_pkg::inst_t  if_inst,
    output fetch_pkg::addr_t  if_pc,
    output logic              if_excep_en,
    output fetch_pkg::ecode_t if_ecode,
    output fetch_pkg::addr_t  if_badv,
    // writeback
    input  logic              flush,
    input  fetch_pkg::addr_t  flush_entry,
    // tlb lookup port 0
    output mmu_pkg::vppn_t    s0_vppn,
    output logic              s0_va_bit12,
    input  logic              s0_found,
    input  mmu_pkg::ppn_t     s0_ppn,
    input  mmu_pkg::ps_t      s0_ps,
    input  mmu_pkg::plv_t     s0_plv,
    input  logic              s0_v,
    // csr state
    input  logic              csr_crmd_pg,
    input  mmu_pkg::plv_t     csr_crmd_plv,
    input  logic              dmw0_plv_met,
    input  mmu_pkg::seg_t     dmw0_vseg,
    input  mmu_pkg::seg_t     dmw0_pseg,
    input  logic              dmw1_plv_met,
    input  mmu_pkg::seg_t     dmw1_vseg,
    input  mmu_pkg::seg_t     dmw1_pseg
);

    logic              req_fire;
    logic              pre_advance;
    logic              if_advance;
    logic              redirect_now;
    logic              cancel_drop;
    logic              buf_data_ok;
    logic              pre_excep;
    fetch_pkg::ecode_t pre_ecode;
    fetch_pkg::addr_t  pre_pc;
    fetch_pkg::addr_t  phys_addr;
    logic              if_ir_valid;
    logic              pre_ir_valid;

    assign inst_sram_addr = phys_addr;
    assign buf_data_ok    = inst_sram_data_ok & ~cancel_drop;   // wrong-path word never lands

    fetch_ctrl ctrl_i (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .id_allowin        (id_allowin),
        .br_taken          (br_taken),
        .br_stall          (br_stall),
        .flush             (flush),
        .pre_excep         (pre_excep),
        .if_excep          (if_excep_en),
        .if_ir_valid       (if_ir_valid),
        .pre_ir_valid      (pre_ir_valid),
        .inst_sram_req     (inst_sram_req),
        .req_fire          (req_fire),
        .pre_advance       (pre_advance),
        .if_advance        (if_advance),
        .if_to_id_valid    (if_to_id_valid),
        .redirect_now      (redirect_now),
        .cancel_drop       (cancel_drop)
    );

    fetch_pc_sel #(
        .RESET_PC (RESET_PC)
    ) pc_sel_i (
        .clk         (clk),
        .resetn      (resetn),
        .req_fire    (req_fire),
        .pre_advance (pre_advance),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .flush       (flush),
        .flush_entry (flush_entry),
        .pre_pc      (pre_pc),
        .if_pc       (if_pc)
    );

    fetch_addr_xlate xlate_i (
        .pre_pc       (pre_pc),
        .csr_crmd_pg  (csr_crmd_pg),
        .csr_crmd_plv (csr_crmd_plv),
        .dmw0_plv_met (dmw0_plv_met),
        .dmw0_vseg    (dmw0_vseg),
        .dmw0_pseg    (dmw0_pseg),
        .dmw1_plv_met (dmw1_plv_met),
        .dmw1_vseg    (dmw1_vseg),
        .dmw1_pseg    (dmw1_pseg),
        .s0_found     (s0_found),
        .s0_ppn       (s0_ppn),
        .s0_ps        (s0_ps),
        .s0_plv       (s0_plv),
        .s0_v         (s0_v),
        .s0_vppn      (s0_vppn),
        .s0_va_bit12  (s0_va_bit12),
        .phys_addr    (phys_addr),
        .pre_excep    (pre_excep),
        .pre_ecode    (pre_ecode)
    );

    fetch_inst_buf inst_buf_i (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_data_ok (buf_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .pre_advance       (pre_advance),
        .if_advance        (if_advance),
        .id_allowin        (id_allowin),
        .redirect_now      (redirect_now),
        .pre_excep         (pre_excep),
        .pre_ecode         (pre_ecode),
        .pre_pc            (pre_pc),
        .if_inst           (if_inst),
        .if_ir_valid       (if_ir_valid),
        .pre_ir_valid      (pre_ir_valid),
        .if_excep_en       (if_excep_en),
        .if_ecode          (if_ecode),
        .if_badv           (if_badv)
    );

endmodule

// File: rtl/fetch_inst_buf.sv
`timescale 1ns/100ps

module fetch_inst_buf (
    input  logic              clk,
    input  logic              resetn,
    input  logic              inst_sram_data_ok,
    input  fetch_pkg::inst_t  inst_sram_rdata,
    input  logic              pre_advance,
    input  logic              if_advance,
    input  logic              id_allowin,
    input  logic              redirect_now,
    input  logic              pre_excep,
    input  fetch_pkg::ecode_t pre_ecode,
    input  fetch_pkg::addr_t  pre_pc,
    output fetch_pkg::inst_t  if_inst,
    output logic              if_ir_valid,
    output logic              pre_ir_valid,
    output logic              if_excep_en,
    output fetch_pkg::ecode_t if_ecode,
    output fetch_pkg::addr_t  if_badv
);

    fetch_pkg::inst_t if_ir;
    fetch_pkg::inst_t pre_ir;
    logic             if_empty;
    logic             data_bypass;
    logic             data_to_if;
    logic             data_to_pre;

    assign if_empty = ~if_ir_valid & ~if_excep_en;  // no word and no exception held

    // word for the waiting fetch entry, taken by decode right away
    assign data_bypass = inst_sram_data_ok & if_empty & if_advance;

    // fetch entry waiting and refused, or the pre-fetch word moving up with its entry
    assign data_to_if = inst_sram_data_ok & ~redirect_now
                      & ((if_empty & ~id_allowin & ~pre_advance)
                         | (pre_advance & ~data_bypass));

    // fetch stage full and staying so
    assign data_to_pre = inst_sram_data_ok & ~redirect_now & ~if_empty & ~pre_advance;

    assign if_inst = if_ir_valid ? if_ir : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            if_ir_valid <= 1'b0;
        end else if (redirect_now) begin
            if_ir_valid <= 1'b0;
        end else if (data_to_if) begin
            if_ir_valid <= 1'b1;
        end else if (pre_advance) begin
            if_ir_valid <= pre_ir_valid;
        end else if (if_advance) begin
            if_ir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (data_to_if) begin
            if_ir <= inst_sram_rdata;
        end else if (pre_advance & pre_ir_valid) begin
            if_ir <= pre_ir;
        end
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            pre_ir_valid <= 1'b0;
        end else if (redirect_now | pre_advance) begin
            pre_ir_valid <= 1'b0;
        end else if (data_to_pre) begin
            pre_ir_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_to_pre) begin
            pre_ir <= inst_sram_rdata;
        end
    end

    // exception record follows the pc into the fetch stage
    always_ff @(posedge clk) begin
        if (~resetn) begin
            if_excep_en <= 1'b0;
        end else if (pre_advance) begin
            if_excep_en <= pre_excep;
        end else if (redirect_now | if_advance) begin
            if_excep_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pre_advance) begin
            if_ecode <= pre_ecode;
            if_badv  <= pre_pc;
        end
    end

endmodule

// File: rtl/fetch_addr_xlate.sv
`timescale 1ns/100ps

module fetch_addr_xlate (
    input  fetch_pkg::addr_t  pre_pc,
    input  logic              csr_crmd_pg,
    input  mmu_pkg::plv_t     csr_crmd_plv,
    input  logic              dmw0_plv_met,
    input  mmu_pkg::seg_t     dmw0_vseg,
    input  mmu_pkg::seg_t     dmw0_pseg,
    input  logic              dmw1_plv_met,
    input  mmu_pkg::seg_t     dmw1_vseg,
    input  mmu_pkg::seg_t     dmw1_pseg,
    input  logic              s0_found,
    input  mmu_pkg::ppn_t     s0_ppn,
    input  mmu_pkg::ps_t      s0_ps,
    input  mmu_pkg::plv_t     s0_plv,
    input  logic              s0_v,
    output mmu_pkg::vppn_t    s0_vppn,
    output logic              s0_va_bit12,
    output fetch_pkg::addr_t  phys_addr,
    output logic              pre_excep,
    output fetch_pkg::ecode_t pre_ecode
);

    mmu_pkg::seg_t    va_seg;
    logic             hit_dmw0;
    logic             hit_dmw1;
    logic             tlb_map;
    fetch_pkg::addr_t mapped_addr;
    logic             excep_adef;
    logic             excep_tlbr;
    logic             excep_pif;
    logic             excep_ppi;

    assign s0_vppn     = pre_pc[31:13];
    assign s0_va_bit12 = pre_pc[12];

    assign va_seg   = pre_pc[31:29];
    assign hit_dmw0 = dmw0_plv_met & (dmw0_vseg == va_seg);
    assign hit_dmw1 = dmw1_plv_met & (dmw1_vseg == va_seg);
    assign tlb_map  = csr_crmd_pg & ~hit_dmw0 & ~hit_dmw1;   // paging on, no window

    always_comb begin
        if (hit_dmw0) begin
            mapped_addr = {dmw0_pseg, pre_pc[28:0]};
        end else if (hit_dmw1) begin
            mapped_addr = {dmw1_pseg, pre_pc[28:0]};
        end else if (s0_ps == mmu_pkg::PS_4M) begin
            mapped_addr = {s0_ppn[19:9], pre_pc[20:0]};
        end else begin
            mapped_addr = {s0_ppn, pre_pc[11:0]};   // 4 KB page
        end
    end

    assign phys_addr = csr_crmd_pg ? mapped_addr : pre_pc;

    assign excep_adef = |pre_pc[1:0];
    assign excep_tlbr = tlb_map & ~s0_found;
    assign excep_pif  = tlb_map & s0_found & ~s0_v;
    assign excep_ppi  = tlb_map & s0_found & s0_v & (csr_crmd_plv > s0_plv);

    assign pre_excep = excep_adef | excep_tlbr | excep_pif | excep_ppi;

    // code only matters when pre_excep is set
    assign pre_ecode = excep_adef ? fetch_pkg::ECODE_ADEF :
                       excep_tlbr ? fetch_pkg::ECODE_TLBR :
                       excep_pif  ? fetch_pkg::ECODE_PIF  :
                                    fetch_pkg::ECODE_PPI;

endmodule

// File: rtl/fetch_pc_sel.sv
`timescale 1ns/100ps

module fetch_pc_sel #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req_fire,
    input  logic             pre_advance,
    input  logic             br_taken,
    input  fetch_pkg::addr_t br_target,
    input  logic             flush,
    input  fetch_pkg::addr_t flush_entry,
    output fetch_pkg::addr_t pre_pc,
    output fetch_pkg::addr_t if_pc
);

    logic             flush_pend;
    fetch_pkg::addr_t flush_pend_pc;
    logic             br_pend;
    fetch_pkg::addr_t br_pend_pc;
    fetch_pkg::addr_t seq_pc;
    logic             redirect_used;

    // an excepting target advances with no request, so either event consumes it
    assign redirect_used = req_fire | pre_advance;

    assign seq_pc = if_pc + 32'd4;

    always_comb begin
        if (flush_pend) begin
            pre_pc = flush_pend_pc;
        end else if (flush) begin
            pre_pc = flush_entry;
        end else if (br_pend) begin
            pre_pc = br_pend_pc;
        end else if (br_taken) begin
            pre_pc = br_target;
        end else begin
            pre_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            flush_pend <= 1'b0;
        end else if (flush & ~redirect_used) begin
            flush_pend <= 1'b1;
        end else if (redirect_used) begin
            flush_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush & ~redirect_used) begin
            flush_pend_pc <= flush_entry;
        end
    end

    // a held branch is dropped together with a held flush, flush wins meanwhile
    always_ff @(posedge clk) begin
        if (~resetn) begin
            br_pend <= 1'b0;
        end else if (br_taken & ~redirect_used) begin
            br_pend <= 1'b1;
        end else if (redirect_used) begin
            br_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken & ~redirect_used) begin
            br_pend_pc <= br_target;
        end
    end

    // one word below the start so that seq_pc hits RESET_PC first
    always_ff @(posedge clk) begin
        if (~resetn) begin
            if_pc <= RESET_PC - 32'd4;
        end else if (pre_advance) begin
            if_pc <= pre_pc;
        end
    end

endmodule

// File: rtl/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic inst_sram_addr_ok,
    input  logic inst_sram_data_ok,
    input  logic id_allowin,
    input  logic br_taken,
    input  logic br_stall,
    input  logic flush,
    input  logic pre_excep,
    input  logic if_excep,
    input  logic if_ir_valid,
    input  logic pre_ir_valid,
    output logic inst_sram_req,
    output logic req_fire,
    output logic pre_advance,
    output logic if_advance,
    output logic if_to_id_valid,
    output logic redirect_now,
    output logic cancel_drop
);

    logic pre_reqed;    // pre-fetch holds an accepted request not yet passed on
    logic if_valid;     // fetch stage holds an entry
    logic cancel;       // one wrong-path request still in flight

    logic data_kept;
    logic if_waiting;
    logic pre_pending;
    logic if_done;
    logic if_ready_go;
    logic if_allowin;
    logic pre_ready_go;

    assign redirect_now = br_taken | flush;

    assign data_kept   = inst_sram_data_ok & ~cancel;
    assign cancel_drop = inst_sram_data_ok & cancel;   // returning word is wrong path

    // the entry in each stage that still waits for its word
    assign if_waiting  = if_valid & ~if_ir_valid & ~if_excep;
    assign pre_pending = pre_reqed & ~pre_ir_valid;

    // fetch stage has nothing outstanding once this cycle ends
    assign if_done = ~if_valid | if_ir_valid | if_excep | data_kept;

    // at most one request in flight so a redirect only ever has one to cancel
    assign inst_sram_req = ~pre_reqed
                         & if_done
                         & (~cancel | inst_sram_data_ok)
                         & ~br_stall
                         & ~pre_excep;
    assign req_fire = inst_sram_req & inst_sram_addr_ok;

    assign if_ready_go = if_ir_valid | if_excep | (if_waiting & data_kept);

    // whatever sits in fetch during a redirect is wrong path
    assign if_to_id_valid = if_valid & if_ready_go & ~redirect_now;
    assign if_advance     = if_to_id_valid & id_allowin;

    assign if_allowin = ~if_valid | if_advance | redirect_now;

    // an excepting pc moves up without a request but not past a pending branch
    assign pre_ready_go = (pre_reqed & ~redirect_now)
                        | req_fire
                        | (pre_excep & ~br_stall);
    assign pre_advance  = pre_ready_go & if_allowin;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            pre_reqed <= 1'b0;
        end else if (pre_advance | redirect_now) begin
            pre_reqed <= 1'b0;
        end else if (req_fire) begin
            pre_reqed <= 1'b1;
        end
    end

    // on redirect only the new target entry may enter
    always_ff @(posedge clk) begin
        if (~resetn) begin
            if_valid <= 1'b0;
        end else if (redirect_now | pre_advance | if_advance) begin
            if_valid <= pre_advance;
        end
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            cancel <= 1'b0;
        end else if (redirect_now & (if_waiting | pre_pending) & ~inst_sram_data_ok) begin
            cancel <= 1'b1;
        end else if (inst_sram_data_ok) begin
            cancel <= 1'b0;                 // the dropped word came back
        end
    end

    a_no_stray_data: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> (cancel | if_waiting | pre_pending))
        else $error("data_ok with no request outstanding");

    // with nothing waiting for a word the dropped one never reaches decode
    a_no_valid_on_cancel: assert property (@(posedge clk) disable iff (!resetn)
        cancel |-> (~if_waiting & ~pre_pending))
        else $error("fetch entry waits for a word while a wrong-path word is pending");

endmodule

// File: rtl/mmu_pkg.sv
package mmu_pkg;

    // top three address bits, matched by the direct-map windows
    typedef logic [2:0] seg_t;

    // physical page number from the tlb
    typedef logic [19:0] ppn_t;

    // virtual page-pair number sent to the tlb
    typedef logic [18:0] vppn_t;

    // privilege level, 0 is most privileged
    typedef logic [1:0] plv_t;

    // tlb page size field
    typedef logic [5:0] ps_t;

    // ps value of a 4 MB page, anything else is treated as 4 KB
    localparam ps_t PS_4M = 6'd21;

endpackage

// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // virtual or physical byte address
    typedef logic [31:0] addr_t;

    // one instruction word as returned by memory
    typedef logic [31:0] inst_t;

    // exception code handed to decode with a faulting fetch
    typedef logic [5:0] ecode_t;

    // fetch address error, low two pc bits nonzero
    localparam ecode_t ECODE_ADEF = 6'h08;

    // tlb refill, mapped address with no matching entry
    localparam ecode_t ECODE_TLBR = 6'h3f;

    // page invalid on fetch
    localparam ecode_t ECODE_PIF  = 6'h03;

    // page privilege illegal
    localparam ecode_t ECODE_PPI  = 6'h07;

endpackage
